// ==== bench/csr_unit_tb.sv ====
/* Testbench of the machine-mode CSR unit
   Drives CSR accesses, traps, interrupts and mret and checks them against a CSR model */
`timescale 1ns/1ps

module csr_unit_tb
  import csr_pkg::*;
();

  localparam int timeout_cycles = 40;

  logic        clock;
  logic        reset_n;
  logic        clock_enable;
  csr_access_t access;
  trap_event_t trap_event;
  logic        mret;
  irq_lines_t  irq;
  logic [63:0] timer;
  logic [31:0] read_data;
  logic        trap_taken;
  logic        trap_return;
  logic [31:0] handler_address;
  logic [31:0] return_address;

  // Expected CSR state
  logic        model_mie;
  logic        model_mpie;
  logic [31:0] model_mie_word;
  logic [31:0] model_mip;
  logic [31:0] model_mtvec;
  logic [31:0] model_mscratch;
  logic [31:0] model_mepc;
  logic [31:0] model_mcause;
  logic [31:0] model_mtval;

  logic        read_check;
  string       read_name;
  logic [31:0] expected_read;
  logic [31:0] expected_handler;
  logic [31:0] expected_return;
  logic        trap_allowed;
  logic        return_allowed;
  int          trap_count;
  int          return_count;

  tb_clock_gen u_clock_gen (.clock, .reset_n);

  csr_unit_top u_dut (
    .clock, .reset_n, .clock_enable, .access, .trap_event, .mret, .irq, .timer,
    .read_data, .trap_taken, .trap_return, .handler_address, .return_address
  );

  function automatic logic [31:0] ref_read(input logic [11:0] addr);
    case (addr)
      csr_addr_mstatus:  return {19'b0, 2'b11, 3'b0, model_mpie, 3'b0, model_mie, 3'b0};
      csr_addr_misa:     return 32'h4000_0100;
      csr_addr_mie:      return model_mie_word;
      csr_addr_mtvec:    return model_mtvec;
      csr_addr_mscratch: return model_mscratch;
      csr_addr_mepc:     return model_mepc;
      csr_addr_mcause:   return model_mcause;
      csr_addr_mtval:    return model_mtval;
      csr_addr_mip:      return model_mip;
      csr_addr_marchid:  return 32'h0000_0018;
      csr_addr_mimpid:   return 32'h0000_0007;
      default:           return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] apply_op(input csr_op_t op, input logic [31:0] old,
                                           input logic [31:0] operand);
    case (op)
      csr_op_rw: return operand;
      csr_op_rs: return old | operand;
      csr_op_rc: return old & ~operand;
      default:   return old;
    endcase
  endfunction

  // Flags ordered fetch, illegal, ebreak, load, store, ecall
  function automatic logic [4:0] exception_code(input logic [5:0] flags);
    if (flags[5]) return 5'd0;
    if (flags[4]) return 5'd2;
    if (flags[3]) return 5'd3;
    if (flags[2]) return 5'd4;
    if (flags[1]) return 5'd6;
    return 5'd11;
  endfunction

  function automatic logic [4:0] irq_code(input irq_lines_t lines);
    for (int i = 0; i < 16; i++) begin
      if (lines.fast[i]) return 5'(16 + i);
    end
    if (lines.software) return 5'd3;
    if (lines.timer) return 5'd7;
    return 5'd11;
  endfunction

  function automatic logic [31:0] ref_handler(input logic interrupt, input logic [4:0] code);
    logic [31:0] base;
    base = {model_mtvec[31:2], 2'b00};
    if (model_mtvec[1:0] == 2'b01 && interrupt) return base + {25'b0, code, 2'b00};
    return base;
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      stop_run();
    end
  endtask

  task automatic model_store(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
      csr_addr_mstatus: begin
        model_mie = value[3];
        model_mpie = value[7];
      end
      csr_addr_mie:      model_mie_word = value & 32'hFFFF_0888;  // 16 fast lines present
      csr_addr_mtvec:    model_mtvec = value & 32'hFFFF_FFFD;
      csr_addr_mscratch: model_mscratch = value;
      csr_addr_mepc:     model_mepc = value & 32'hFFFF_FFFC;
      csr_addr_mcause:   model_mcause = value;
      csr_addr_mtval:    model_mtval = value;
      default: ;
    endcase
  endtask

  task automatic write_csr(input csr_op_t op, input logic imm_form, input logic [11:0] addr,
                           input logic [31:0] operand);
    logic [31:0] effective;
    effective = imm_form ? {27'b0, operand[4:0]} : operand;
    access.write_request = 1'b1;
    access.immediate_form = imm_form;
    access.op = op;
    access.addr = addr;
    access.imm = operand[4:0];
    access.rs1_data = imm_form ? $urandom : operand;  // Ignored in immediate form
    model_store(addr, apply_op(op, ref_read(addr), effective));
    @(negedge clock);
    access.write_request = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr, input logic [31:0] expected,
                          input string name);
    access.write_request = 1'b0;
    access.addr = addr;
    expected_read = expected;
    read_name = name;
    read_check = 1'b1;
    @(negedge clock);
    read_check = 1'b0;
  endtask

  task automatic wait_pulse(input logic is_return, input int start);
    int count;
    for (int i = 0; i < timeout_cycles; i++) begin
      @(negedge clock);
      count = is_return ? return_count : trap_count;
      if (count != start) return;
    end
    $display("ERROR: no %s pulse within %0d cycles", is_return ? "trap_return" : "trap_taken",
             timeout_cycles);
    stop_run();
  endtask

  // Exception when flags are set, otherwise an interrupt from lines
  task automatic run_trap(input logic [5:0] flags, input irq_lines_t lines);
    logic [31:0] pc;
    logic [31:0] target;
    logic [4:0]  code;
    logic        interrupt;
    int          start;
    pc = $urandom & 32'hFFFF_FFFC;
    target = $urandom;
    interrupt = (flags == 6'b0);
    code = interrupt ? irq_code(lines) : exception_code(flags);
    expected_handler = ref_handler(interrupt, code);
    start = trap_count;
    trap_allowed = 1'b1;
    trap_event = {flags, pc, target};
    irq = lines;
    model_mip = {lines.fast, 4'b0, lines.external, 3'b0, lines.timer, 3'b0, lines.software, 3'b0};
    wait_pulse(1'b0, start);
    trap_allowed = 1'b0;  // A second pulse is an error
    trap_event = '0;
    model_mepc = pc;
    if (interrupt) model_mtval = '0;
    else if (flags[5] || flags[2] || flags[1]) model_mtval = target;
    else if (flags[3]) model_mtval = pc;
    else model_mtval = '0;
    model_mcause = {interrupt, 26'b0, code};
    model_mpie = model_mie;
    model_mie = 1'b0;
    read_csr(csr_addr_mcause, ref_read(csr_addr_mcause), "mcause");
    read_csr(csr_addr_mepc, ref_read(csr_addr_mepc), "mepc");
    read_csr(csr_addr_mtval, ref_read(csr_addr_mtval), "mtval");
    read_csr(csr_addr_mstatus, ref_read(csr_addr_mstatus), "mstatus");
  endtask

  task automatic expect_no_trap();
    int start;
    start = trap_count;
    for (int i = 0; i < timeout_cycles; i++) begin
      @(negedge clock);
      if (trap_count != start) begin
        $display("ERROR: interrupt trap taken while mstatus.MIE is clear");
        stop_run();
      end
    end
  endtask

  task automatic run_mret();
    int start;
    start = return_count;
    expected_return = model_mepc;
    return_allowed = 1'b1;
    mret = 1'b1;
    @(negedge clock);
    mret = 1'b0;
    wait_pulse(1'b1, start);
    return_allowed = 1'b0;
    model_mie = model_mpie;
    model_mpie = 1'b1;
    read_csr(csr_addr_mstatus, ref_read(csr_addr_mstatus), "mstatus");
  endtask

  task automatic wait_reset();
    for (int i = 0; i < 20; i++) begin
      @(negedge clock);
      if (reset_n === 1'b1) return;
    end
    $display("ERROR: reset_n was never released");
    stop_run();
  endtask

  // Samples just before each rising edge
  always @(posedge clock) begin
    if (read_check) check_value(read_name, read_data, expected_read);
    if (trap_taken === 1'b1) begin
      if (!trap_allowed) begin
        $display("ERROR: trap_taken pulsed when no trap was expected");
        stop_run();
      end
      check_value("handler_address", handler_address, expected_handler);
      trap_count++;
    end
    if (trap_return === 1'b1) begin
      if (!return_allowed) begin
        $display("ERROR: trap_return pulsed when no mret was expected");
        stop_run();
      end
      check_value("return_address", return_address, expected_return);
      return_count++;
    end
  end

  initial begin
    logic [11:0] addr;
    string       name;
    int          pick;
    int          cycles;
    logic [31:0] value;
    logic [63:0] stamp;
    irq_lines_t  lines;
    void'($urandom(32'h3705_ac5c));
    clock_enable = 1'b1;
    access = '0;
    trap_event = '0;
    mret = 1'b0;
    irq = '0;
    timer = '0;
    read_check = 1'b0;
    read_name = "";
    expected_read = '0;
    expected_handler = '0;
    expected_return = '0;
    trap_allowed = 1'b0;
    return_allowed = 1'b0;
    trap_count = 0;
    return_count = 0;
    model_mie = 1'b0;
    model_mpie = 1'b1;
    model_mie_word = '0;
    model_mip = '0;
    model_mtvec = '0;
    model_mscratch = '0;
    model_mepc = '0;
    model_mcause = '0;
    model_mtval = '0;
    wait_reset();
    @(negedge clock);

    // Reset values and constants
    check_value("trap_taken", {31'b0, trap_taken}, 32'h0);
    read_csr(csr_addr_mstatus, 32'h0000_1880, "mstatus");
    read_csr(csr_addr_mie, 32'h0, "mie");
    read_csr(csr_addr_mip, 32'h0, "mip");
    read_csr(csr_addr_mtvec, 32'h0, "mtvec");
    read_csr(csr_addr_mepc, 32'h0, "mepc");
    read_csr(csr_addr_misa, 32'h4000_0100, "misa");
    read_csr(csr_addr_marchid, 32'h0000_0018, "marchid");
    read_csr(csr_addr_mimpid, 32'h0000_0007, "mimpid");
    read_csr(csr_addr_mstatush, 32'h0, "mstatush");
    read_csr(12'h7C0, 32'h0, "unknown CSR");

    for (int n = 0; n < 30; n++) begin
      pick = $urandom_range(2, 0);
      addr = (pick == 0) ? csr_addr_mscratch : (pick == 1) ? csr_addr_mtvec : csr_addr_mepc;
      name = (pick == 0) ? "mscratch" : (pick == 1) ? "mtvec" : "mepc";
      write_csr(csr_op_t'(2'($urandom_range(3, 1))), 1'($urandom_range(1, 0)), addr, $urandom);
      read_csr(addr, ref_read(addr), name);
    end

    // One exception flag at a time, direct mode
    write_csr(csr_op_rw, 1'b0, csr_addr_mtvec, 32'h0000_2000);
    for (int k = 0; k < 6; k++) begin
      write_csr(csr_op_rw, 1'b0, csr_addr_mstatus, $urandom & 32'h0000_0088);
      run_trap(6'(6'b10_0000 >> k), '0);
      run_mret();
    end

    // Interrupts, vectored mode
    write_csr(csr_op_rw, 1'b0, csr_addr_mtvec, 32'h0000_3001);
    write_csr(csr_op_rw, 1'b0, csr_addr_mie, 32'hFFFF_FFFF);
    read_csr(csr_addr_mie, ref_read(csr_addr_mie), "mie");
    write_csr(csr_op_rs, 1'b1, csr_addr_mstatus, 32'h0000_0008);
    for (int k = 0; k < 6; k++) begin
      lines = irq_lines_t'(19'($urandom));
      if (lines == '0) lines.external = 1'b1;
      run_trap(6'b0, lines);
      read_csr(csr_addr_mip, ref_read(csr_addr_mip), "mip");
      expect_no_trap();  // Lines still held, MIE now clear
      irq = '0;
      model_mip = '0;
      @(negedge clock);
      read_csr(csr_addr_mip, 32'h0, "mip");
      run_mret();
    end

    value = $urandom & 32'h0FFF_FFFF;
    cycles = $urandom_range(10, 3);
    write_csr(csr_op_rw, 1'b0, csr_addr_mcycle, value);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clock);
    end
    read_csr(csr_addr_mcycle, value + 32'(cycles) + 32'd1, "mcycle");

    // Stall right after loading minstret
    value = $urandom & 32'h0FFF_FFFF;
    write_csr(csr_op_rw, 1'b0, csr_addr_minstret, value);
    clock_enable = 1'b0;
    for (int n = 0; n < 6; n++) begin
      @(negedge clock);
    end
    read_csr(csr_addr_minstret, value + 32'd1, "minstret");
    clock_enable = 1'b1;

    stamp = {$urandom, $urandom};
    timer = stamp;
    @(negedge clock);
    timer = ~stamp;
    read_csr(csr_addr_time, stamp[31:0], "time");
    read_csr(csr_addr_timeh, ~stamp[63:32], "timeh");

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
/* Clock and reset for the CSR unit testbench
   40 ns clock, reset held low for the first 8 cycles */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period = 20,
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;  // Released on a falling edge
  end

endmodule

// ==== common/csr_pkg.sv ====
/* Shared addresses, encodings and types of the machine-mode CSR unit
   Imported by every module of the unit and by the testbench */
package csr_pkg;

  localparam int max_fast_irq = 16;  // Upper bound for num_fast_irq

  // Machine information and status
  localparam logic [11:0] csr_addr_mstatus   = 12'h300;
  localparam logic [11:0] csr_addr_misa      = 12'h301;
  localparam logic [11:0] csr_addr_mie       = 12'h304;
  localparam logic [11:0] csr_addr_mtvec     = 12'h305;
  localparam logic [11:0] csr_addr_mstatush  = 12'h310;
  localparam logic [11:0] csr_addr_mscratch  = 12'h340;
  localparam logic [11:0] csr_addr_mepc      = 12'h341;
  localparam logic [11:0] csr_addr_mcause    = 12'h342;
  localparam logic [11:0] csr_addr_mtval     = 12'h343;
  localparam logic [11:0] csr_addr_mip       = 12'h344;
  localparam logic [11:0] csr_addr_marchid   = 12'hF12;
  localparam logic [11:0] csr_addr_mimpid    = 12'hF13;

  // Writable counters
  localparam logic [11:0] csr_addr_mcycle    = 12'hB00;
  localparam logic [11:0] csr_addr_minstret  = 12'hB02;
  localparam logic [11:0] csr_addr_mcycleh   = 12'hB80;
  localparam logic [11:0] csr_addr_minstreth = 12'hB82;

  // Read-only user shadows
  localparam logic [11:0] csr_addr_cycle     = 12'hC00;
  localparam logic [11:0] csr_addr_time      = 12'hC01;
  localparam logic [11:0] csr_addr_instret   = 12'hC02;
  localparam logic [11:0] csr_addr_cycleh    = 12'hC80;
  localparam logic [11:0] csr_addr_timeh     = 12'hC81;
  localparam logic [11:0] csr_addr_instreth  = 12'hC82;

  localparam logic [31:0] csr_misa_value    = 32'h4000_0100;  // RV32I, no extensions
  localparam logic [31:0] csr_marchid_value = 32'h0000_0018;
  localparam logic [31:0] csr_mimpid_value  = 32'h0000_0007;

  typedef enum logic [1:0] {
    csr_op_none = 2'b00,
    csr_op_rw   = 2'b01,
    csr_op_rs   = 2'b10,
    csr_op_rc   = 2'b11
  } csr_op_t;

  typedef enum logic [1:0] {
    state_operating   = 2'b00,
    state_trap_taken  = 2'b01,
    state_trap_return = 2'b10
  } core_state_t;

  typedef struct packed {
    logic        write_request;
    logic        immediate_form;  // Operand from imm, not rs1
    csr_op_t     op;
    logic [11:0] addr;
    logic [4:0]  imm;
    logic [31:0] rs1_data;
    logic [2:0]  pad;
  } csr_access_t;

  typedef struct packed {
    logic        misaligned_fetch;
    logic        illegal;
    logic        ebreak;
    logic        misaligned_load;
    logic        misaligned_store;
    logic        ecall;
    logic [31:0] pc;
    logic [31:0] target;  // Faulting address for misaligned accesses
  } trap_event_t;

  typedef struct packed {
    logic [max_fast_irq-1:0] fast;
    logic                    software;
    logic                    timer;
    logic                    external;
  } irq_lines_t;

  typedef struct packed {
    logic        interrupt;
    logic [25:0] reserved;
    logic [4:0]  code;
  } mcause_fields_t;

  // Read whole as the CSR, decoded for vectoring
  typedef union packed {
    logic [31:0]    raw;
    mcause_fields_t field;
  } mcause_word_u;

endpackage

// ==== csr/csr_counters.sv ====
/* 64-bit cycle, instret and time counters
   Cycle and instret halves are writable through the CSR port */
`timescale 1ns/1ps

module csr_counters
  import csr_pkg::*;
(
  input  logic        clock,
  input  logic        reset_n,
  input  logic        clock_enable,
  input  core_state_t state,
  input  csr_access_t access,
  input  logic [31:0] write_data,
  input  logic [63:0] timer,
  output logic [63:0] mcycle,
  output logic [63:0] minstret,
  output logic [63:0] utime
);

  logic write_request;
  logic mcycle_lo_write;
  logic mcycle_hi_write;
  logic minstret_lo_write;
  logic minstret_hi_write;
  logic operating;

  function automatic logic [63:0] load_half(input logic [63:0] value, input logic high_half,
                                            input logic [31:0] data);
    return high_half ? {data, value[31:0]} : {value[63:32], data};
  endfunction

  assign write_request = clock_enable && access.write_request;
  assign mcycle_lo_write = write_request && access.addr == csr_addr_mcycle;
  assign mcycle_hi_write = write_request && access.addr == csr_addr_mcycleh;
  assign minstret_lo_write = write_request && access.addr == csr_addr_minstret;
  assign minstret_hi_write = write_request && access.addr == csr_addr_minstreth;
  assign operating = state == state_operating;

  // Counts through stalls
  always_ff @(posedge clock) begin
    if (!reset_n) mcycle <= '0;
    else if (mcycle_lo_write || mcycle_hi_write)
      mcycle <= load_half(mcycle, mcycle_hi_write, write_data) + 64'd1;
    else mcycle <= mcycle + 64'd1;
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      minstret <= '0;
    end else if (clock_enable) begin
      if (minstret_lo_write || minstret_hi_write)
        minstret <= load_half(minstret, minstret_hi_write, write_data) + 64'(operating);
      else if (operating) minstret <= minstret + 64'd1;  // Retires only when operating
    end
  end

  always_ff @(posedge clock) begin
    utime <= timer;
  end

endmodule

// ==== csr/csr_machine_regs.sv ====
/* Machine-mode status, enable, vector, epc, cause, tval and scratch registers
   Computes the CSR write value and drives the combinational read port */
`timescale 1ns/1ps

module csr_machine_regs
  import csr_pkg::*;
#(
  parameter int num_fast_irq = max_fast_irq
) (
  input  logic         clock,
  input  logic         reset_n,
  input  logic         clock_enable,
  input  core_state_t  state,
  input  logic         take_trap,
  input  csr_access_t  access,
  input  trap_event_t  trap_event,
  input  mcause_word_u cause,
  input  logic [31:0]  mip_word,
  input  logic [63:0]  mcycle,
  input  logic [63:0]  minstret,
  input  logic [63:0]  utime,
  output logic [31:0]  write_data,
  output logic [31:0]  read_data,
  output logic [31:0]  mie_word,
  output logic         global_enable,
  output logic [31:0]  handler_address,
  output logic [31:0]  return_address
);

  logic                    mstatus_mie;
  logic                    mstatus_mpie;
  logic [max_fast_irq-1:0] mie_fast;
  logic                    mie_meie;
  logic                    mie_mtie;
  logic                    mie_msie;
  logic [31:0]             mtvec;
  logic [31:0]             mscratch;
  logic [31:0]             mepc;
  mcause_word_u            mcause;
  logic [31:0]             mtval;
  logic [31:0]             mstatus_word;
  logic [31:0]             operand;
  logic [31:0]             handler_base;
  logic                    misaligned;
  logic                    any_write;
  logic                    operating_write;

  assign operand = access.immediate_form ? {27'b0, access.imm} : access.rs1_data;
  assign any_write = clock_enable && access.write_request;
  assign operating_write = any_write && state == state_operating;
  assign misaligned = trap_event.misaligned_fetch | trap_event.misaligned_load |
                      trap_event.misaligned_store;

  // MPP always reads as M-mode
  assign mstatus_word = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
  assign mie_word = {mie_fast, 4'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
  assign global_enable = mstatus_mie;
  assign return_address = mepc;

  // Vectored mode only offsets interrupts
  assign handler_base = {mtvec[31:2], 2'b00};
  assign handler_address = (mtvec[1:0] == 2'b01 && cause.field.interrupt) ?
      handler_base + {25'b0, cause.field.code, 2'b00} : handler_base;

  always_comb begin
    case (access.addr)
      csr_addr_mstatus:   read_data = mstatus_word;
      csr_addr_misa:      read_data = csr_misa_value;
      csr_addr_mie:       read_data = mie_word;
      csr_addr_mtvec:     read_data = mtvec;
      csr_addr_mscratch:  read_data = mscratch;
      csr_addr_mepc:      read_data = mepc;
      csr_addr_mcause:    read_data = mcause.raw;
      csr_addr_mtval:     read_data = mtval;
      csr_addr_mip:       read_data = mip_word;
      csr_addr_marchid:   read_data = csr_marchid_value;
      csr_addr_mimpid:    read_data = csr_mimpid_value;
      csr_addr_mcycle,
      csr_addr_cycle:     read_data = mcycle[31:0];
      csr_addr_mcycleh,
      csr_addr_cycleh:    read_data = mcycle[63:32];
      csr_addr_minstret,
      csr_addr_instret:   read_data = minstret[31:0];
      csr_addr_minstreth,
      csr_addr_instreth:  read_data = minstret[63:32];
      csr_addr_time:      read_data = utime[31:0];
      csr_addr_timeh:     read_data = utime[63:32];
      default:            read_data = 32'h0;  // Includes mstatush
    endcase
  end

  always_comb begin
    case (access.op)
      csr_op_rw: write_data = operand;
      csr_op_rs: write_data = read_data | operand;
      csr_op_rc: write_data = read_data & ~operand;
      default:   write_data = read_data;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b1;
    end else if (clock_enable) begin
      if (state == state_trap_return) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end else if (state == state_trap_taken) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
      end else if (operating_write && access.addr == csr_addr_mstatus) begin
        mstatus_mie  <= write_data[3];
        mstatus_mpie <= write_data[7];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mie_fast <= '0;
      mie_meie <= 1'b0;
      mie_mtie <= 1'b0;
      mie_msie <= 1'b0;
    end else if (any_write && access.addr == csr_addr_mie) begin
      for (int i = 0; i < max_fast_irq; i++) begin
        mie_fast[i] <= (i < num_fast_irq) ? write_data[16 + i] : 1'b0;  // Absent lines stay 0
      end
      mie_meie <= write_data[11];
      mie_mtie <= write_data[7];
      mie_msie <= write_data[3];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mtvec    <= '0;
      mscratch <= '0;
    end else if (any_write) begin
      if (access.addr == csr_addr_mtvec) mtvec <= {write_data[31:2], 1'b0, write_data[0]};
      if (access.addr == csr_addr_mscratch) mscratch <= write_data;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mepc  <= '0;
      mtval <= '0;
    end else if (clock_enable) begin
      if (take_trap) begin
        mepc <= trap_event.pc;
        if (misaligned) mtval <= trap_event.target;
        else if (trap_event.ebreak) mtval <= trap_event.pc;
        else mtval <= '0;
      end else if (operating_write) begin
        if (access.addr == csr_addr_mepc) mepc <= {write_data[31:2], 2'b00};
        if (access.addr == csr_addr_mtval) mtval <= write_data;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mcause <= '0;
    end else if (clock_enable) begin
      if (state == state_trap_taken) mcause <= cause;
      else if (operating_write && access.addr == csr_addr_mcause) mcause.raw <= write_data;
    end
  end

  mtvec_bit1_zero: assert property (@(posedge clock) disable iff (!reset_n)
    mtvec[1] == 1'b0);

endmodule

// ==== csr/csr_trap_cause.sv ====
/* Samples the interrupt lines into mip and registers the prioritised trap cause
   The cause feeds mcause and the vectored handler address */
`timescale 1ns/1ps

module csr_trap_cause
  import csr_pkg::*;
#(
  parameter int num_fast_irq = max_fast_irq
) (
  input  logic         clock,
  input  logic         reset_n,
  input  logic         clock_enable,
  input  core_state_t  state,
  input  trap_event_t  trap_event,
  input  irq_lines_t   irq,
  input  logic [31:0]  mie_word,
  input  logic         global_enable,
  output logic         interrupt_pending,
  output logic [31:0]  mip_word,
  output mcause_word_u cause
);

  logic [max_fast_irq-1:0] mip_fast;
  logic                    mip_meip;
  logic                    mip_mtip;
  logic                    mip_msip;
  logic [31:0]             enabled;
  logic [4:0]              irq_code;
  mcause_word_u            cause_next;

  function automatic mcause_word_u make_cause(input logic interrupt, input logic [4:0] code);
    mcause_word_u word;
    word.field.interrupt = interrupt;
    word.field.reserved  = '0;
    word.field.code      = code;
    return word;
  endfunction

  // Sampled every clock, even while stalled
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      mip_fast <= '0;
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
    end else begin
      for (int i = 0; i < max_fast_irq; i++) begin
        mip_fast[i] <= (i < num_fast_irq) ? irq.fast[i] : 1'b0;
      end
      mip_meip <= irq.external;
      mip_mtip <= irq.timer;
      mip_msip <= irq.software;
    end
  end

  assign mip_word = {mip_fast, 4'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};
  assign enabled = mip_word & mie_word;
  assign interrupt_pending = |enabled;

  // Lowest priority assigned first, so the last match wins
  always_comb begin
    irq_code = 5'd0;
    if (enabled[11]) irq_code = 5'd11;
    if (enabled[7]) irq_code = 5'd7;
    if (enabled[3]) irq_code = 5'd3;
    for (int i = num_fast_irq - 1; i >= 0; i--) begin
      if (enabled[16 + i]) irq_code = 5'(16 + i);
    end
  end

  always_comb begin
    cause_next = cause;
    if (trap_event.misaligned_fetch) cause_next = make_cause(1'b0, 5'd0);
    else if (trap_event.illegal) cause_next = make_cause(1'b0, 5'd2);
    else if (trap_event.ebreak) cause_next = make_cause(1'b0, 5'd3);
    else if (trap_event.misaligned_load) cause_next = make_cause(1'b0, 5'd4);
    else if (trap_event.misaligned_store) cause_next = make_cause(1'b0, 5'd6);
    else if (trap_event.ecall) cause_next = make_cause(1'b0, 5'd11);
    else if (global_enable && interrupt_pending) cause_next = make_cause(1'b1, irq_code);
  end

  always_ff @(posedge clock) begin
    if (!reset_n) cause <= '0;
    else if (clock_enable && state == state_operating) cause <= cause_next;
  end

  // Interrupt codes are only the standard three or a fast line
  irq_code_legal: assert property (@(posedge clock) disable iff (!reset_n)
    cause.field.interrupt |-> (cause.field.code inside {5'd3, 5'd7, 5'd11} ||
                               cause.field.code >= 5'd16));

endmodule

// ==== rtl/csr_unit_top.sv ====
/* Machine-mode CSR unit of a small RV32I core
   Connects the trap sequencer, CSR registers, cause logic and counters */
`timescale 1ns/1ps

module csr_unit_top
  import csr_pkg::*;
#(
  parameter int num_fast_irq = max_fast_irq  // 1 to 16
) (
  input  logic        clock,
  input  logic        reset_n,
  input  logic        clock_enable,
  input  csr_access_t access,
  input  trap_event_t trap_event,
  input  logic        mret,
  input  irq_lines_t  irq,
  input  logic [63:0] timer,
  output logic [31:0] read_data,
  output logic        trap_taken,
  output logic        trap_return,
  output logic [31:0] handler_address,
  output logic [31:0] return_address
);

  core_state_t  state;
  logic         take_trap;
  logic         interrupt_pending;
  logic         global_enable;
  mcause_word_u cause;
  logic [31:0]  mip_word;
  logic [31:0]  mie_word;
  logic [31:0]  write_data;
  logic [63:0]  mcycle;
  logic [63:0]  minstret;
  logic [63:0]  utime;

  trap_sequencer u_sequencer (
    .clock, .reset_n, .clock_enable, .trap_event, .mret, .interrupt_pending,
    .global_enable, .state, .take_trap, .trap_taken, .trap_return
  );

  csr_machine_regs #(.num_fast_irq(num_fast_irq)) u_machine_regs (
    .clock, .reset_n, .clock_enable, .state, .take_trap, .access, .trap_event,
    .cause, .mip_word, .mcycle, .minstret, .utime, .write_data, .read_data,
    .mie_word, .global_enable, .handler_address, .return_address
  );

  csr_trap_cause #(.num_fast_irq(num_fast_irq)) u_trap_cause (
    .clock, .reset_n, .clock_enable, .state, .trap_event, .irq, .mie_word,
    .global_enable, .interrupt_pending, .mip_word, .cause
  );

  csr_counters u_counters (
    .clock, .reset_n, .clock_enable, .state, .access, .write_data, .timer,
    .mcycle, .minstret, .utime
  );

endmodule

// ==== rtl/trap_sequencer.sv ====
/* Stand-in for the core state machine around the CSR unit
   Takes traps and mret returns as single-cycle states */
`timescale 1ns/1ps

module trap_sequencer
  import csr_pkg::*;
(
  input  logic        clock,
  input  logic        reset_n,
  input  logic        clock_enable,
  input  trap_event_t trap_event,
  input  logic        mret,
  input  logic        interrupt_pending,
  input  logic        global_enable,
  output core_state_t state,
  output logic        take_trap,
  output logic        trap_taken,
  output logic        trap_return
);

  core_state_t state_next;
  logic        exception;

  assign exception = trap_event.misaligned_fetch | trap_event.illegal | trap_event.ebreak |
                     trap_event.misaligned_load | trap_event.misaligned_store | trap_event.ecall;
  assign take_trap = state == state_operating &&
                     (exception || (interrupt_pending && global_enable));

  always_comb begin
    case (state)
      state_operating: begin
        if (take_trap) state_next = state_trap_taken;  // Trap wins over mret
        else if (mret) state_next = state_trap_return;
        else state_next = state_operating;
      end
      default: state_next = state_operating;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) state <= state_operating;
    else if (clock_enable) state <= state_next;
  end

  assign trap_taken = state == state_trap_taken;
  assign trap_return = state == state_trap_return;

  trap_pulse_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
    !(trap_taken && trap_return));

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the CSR unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
  --top-module csr_unit_tb -o csr_unit_sim \
  && { ./obj_dir/csr_unit_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null; } \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src.f ====
common/csr_pkg.sv
csr/csr_machine_regs.sv
csr/csr_trap_cause.sv
csr/csr_counters.sv
rtl/trap_sequencer.sv
rtl/csr_unit_top.sv
bench/tb_clock_gen.sv
bench/csr_unit_tb.sv
